// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f \
    --top-module mem_subsys_tb -o mem_subsys_sim

# The log search below decides the result, so a failing run must not stop the script here.
./obj_dir/mem_subsys_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation result: pass"
    exit 0
fi
echo "Simulation result: FAIL"
exit 1

// ==== sources.f ====
verilog/mem_pkg.sv
verilog/data_ram.sv
verilog/lsu_request.sv
verilog/op_fifo.sv
verilog/load_extend.sv
verilog/mem_subsys_top.sv
verif/mem_subsys_props.sv
verif/mem_subsys_tb.sv

// ==== verif/mem_patterns.txt ====
# op addr wdata exp_rdata exp_err, all hex. Ops are 0 LB, 1 LBU, 2 LH, 3 LHU,
# 4 LW, 5 SB, 6 SH, 7 SW, f NOP. Stores expect zero read data.
7 00000100 11223344 00000000 0
4 00000100 00000000 11223344 0
7 00000104 00000000 00000000 0
5 00000104 000000a5 00000000 0
5 00000105 0000007f 00000000 0
5 00000106 00000080 00000000 0
5 00000107 123456c3 00000000 0
4 00000104 00000000 c3807fa5 0
0 00000104 00000000 ffffffa5 0
1 00000104 00000000 000000a5 0
0 00000105 00000000 0000007f 0
0 00000106 00000000 ffffff80 0
1 00000107 00000000 000000c3 0
0 00000107 00000000 ffffffc3 0
7 00000108 ffffffff 00000000 0
6 00000108 00008001 00000000 0
6 0000010a 00007ffe 00000000 0
4 00000108 00000000 7ffe8001 0
2 00000108 00000000 ffff8001 0
3 00000108 00000000 00008001 0
2 0000010a 00000000 00007ffe 0
3 0000010a 00000000 00007ffe 0
2 00000109 00000000 00000000 1
6 0000010b 0000aaaa 00000000 1
4 0000010a 00000000 00000000 1
7 00000101 deadbeef 00000000 1
4 00000108 00000000 7ffe8001 0
4 00000100 00000000 11223344 0
f 00000100 00000000 00000000 0
7 0000010c cafef00d 00000000 0
4 0000010c 00000000 cafef00d 0
5 0000010d 00000011 00000000 0
3 0000010c 00000000 0000110d 0
0 0000010f 00000000 ffffffca 0

// ==== verif/mem_subsys_props.sv ====
`timescale 1ns/10ps

module mem_subsys_props #(
    parameter int DELAY = 2
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty,
    input logic data_req,
    input logic data_addr_ok,
    input logic data_data_ok
);

    // Tag FIFO holds one slot more than the responses in flight.
    no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("tag pushed while the FIFO is full");

    no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("tag popped while the FIFO is empty");

    // An accepted request has its tag at the FIFO head one cycle later.
    accept_leaves_tag: assert property (@(posedge clk) disable iff (rst)
        data_addr_ok |=> !empty)
        else $error("accepted request left no tag in the FIFO");

    data_ok_delayed: assert property (@(posedge clk) disable iff (rst)
        data_data_ok == $past(data_req, DELAY))
        else $error("data_data_ok does not follow data_req by DELAY cycles");

endmodule

bind mem_subsys_top mem_subsys_props #(.DELAY(DELAY)) props_i (
    .clk, .rst, .push, .pop,
    .full(op_fifo_i.full), .empty(op_fifo_i.empty),
    .data_req, .data_addr_ok, .data_data_ok
);

// ==== verif/mem_subsys_tb.sv ====
`timescale 1ns/10ps

module mem_subsys_tb import mem_pkg::*; ();

    localparam int DELAY       = DEFAULT_DELAY;
    localparam int RAND_BASE   = 32'h200;
    localparam int RAND_WORDS  = 16;
    localparam int RAND_OPS    = 200;
    localparam int DRAIN_LIMIT = 50;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    lsu_op_e     cmd_op;
    logic [31:0] cmd_addr;
    logic [31:0] cmd_wdata;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        addr_err;

    int cyc;
    int data_errs;
    int time_errs;
    int flag_errs;
    int other_errs;
    bit timed_out;

    logic [31:0] exp_data [$];
    int          exp_cyc [$];
    string       exp_name [$];
    int          err_cyc [$];
    string       err_name [$];

    logic [7:0] ref_bytes [4*RAND_WORDS];  // Byte image of the random region.

    mem_subsys_top dut_i (
        .clk, .rst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_wdata,
        .rsp_valid, .rsp_rdata, .addr_err
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ##########################################################
    // Driver and reference model
    // ##########################################################

    task automatic send_cmd(input lsu_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rd,
                            input bit exp_err, input string name);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_wdata <= wdata;
        if (exp_err) begin
            err_cyc.push_back(cyc + 2);  // Registered one cycle after the command.
            err_name.push_back(name);
        end else if (op != NOP) begin
            exp_data.push_back(exp_rd);
            exp_cyc.push_back(cyc + 1 + DELAY);
            exp_name.push_back(name);
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_op    <= NOP;
    endtask

    function automatic void store_model(input lsu_op_e op, input int off,
                                        input logic [31:0] wdata);
        int nbytes;
        nbytes = (op == SB) ? 1 : (op == SH) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            ref_bytes[off + b] = wdata[8*b +: 8];  // Little-endian lanes.
        end
    endfunction

    function automatic logic [31:0] load_model(input lsu_op_e op, input int off);
        case (op)
            LB:      return {{24{ref_bytes[off][7]}}, ref_bytes[off]};
            LBU:     return {24'd0, ref_bytes[off]};
            LH:      return {{16{ref_bytes[off+1][7]}}, ref_bytes[off+1], ref_bytes[off]};
            LHU:     return {16'd0, ref_bytes[off+1], ref_bytes[off]};
            default: return {ref_bytes[off+3], ref_bytes[off+2], ref_bytes[off+1], ref_bytes[off]};
        endcase
    endfunction

    task automatic run_patterns();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rd;
        logic        exp_err;
        fd = $fopen("verif/mem_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/mem_patterns.txt");
            other_errs++;
        end else begin
            line_no = 0;
            while ($fgets(line, fd) != 0) begin
                line_no++;
                n = $sscanf(line, "%h %h %h %h %h", op, addr, wdata, exp_rd, exp_err);
                if (n == 5) begin  // Comment lines do not scan.
                    send_cmd(lsu_op_e'(op), addr, wdata, exp_rd, exp_err,
                             $sformatf("pattern line %0d", line_no));
                end
            end
            $fclose(fd);
            go_idle();
        end
    endtask

    task automatic run_random();
        lsu_op_e     op;
        int          off;
        logic [31:0] wdata;
        string       name;
        for (int w = 0; w < RAND_WORDS; w++) begin
            wdata = $urandom();
            store_model(SW, 4*w, wdata);
            send_cmd(SW, RAND_BASE + 4*w, wdata, 32'd0, 1'b0, $sformatf("random init %0d", w));
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            op    = lsu_op_e'(4'($urandom_range(0, 7)));
            off   = $urandom_range(0, 4*RAND_WORDS - 1);
            wdata = $urandom();
            name  = $sformatf("random op %0d", i);
            if (op == LH || op == LHU || op == SH) begin
                off = off & ~1;
            end else if (op == LW || op == SW) begin
                off = off & ~3;
            end
            if (op == SB || op == SH || op == SW) begin
                store_model(op, off, wdata);
                send_cmd(op, RAND_BASE + off, wdata, 32'd0, 1'b0, name);
                if ($urandom_range(0, 1) == 1) begin  // Load right behind the store.
                    send_cmd(LW, RAND_BASE + (off & ~3), 32'd0, load_model(LW, off & ~3),
                             1'b0, {name, " reload"});
                end
            end else begin
                send_cmd(op, RAND_BASE + off, 32'd0, load_model(op, off), 1'b0, name);
            end
        end
        go_idle();
    endtask

    task automatic wait_drain(input string phase);
        int t;
        t = 0;
        while ((exp_data.size() > 0 || err_cyc.size() > 0) && t < DRAIN_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (exp_data.size() > 0 || err_cyc.size() > 0) begin
            $display("Timed out in %s phase with %0d responses and %0d addr_err pulses missing",
                     phase, exp_data.size(), err_cyc.size());
            timed_out = 1'b1;
            other_errs++;
        end
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            if (rsp_valid !== 1'b0 || addr_err !== 1'b0) begin
                $display("rsp_valid or addr_err is not low after reset at cycle %0d", cyc);
                other_errs++;
            end
        end
    endtask

    // ##########################################################
    // Response monitor
    // ##########################################################

    always @(negedge clk) begin
        if (!rst) begin
            if (rsp_valid) begin
                if (exp_data.size() == 0) begin
                    $display("Response at cycle %0d with no command waiting for it", cyc);
                    other_errs++;
                end else begin
                    if (rsp_rdata !== exp_data[0]) begin
                        $display("** Error %s: expected %h, actual %h",
                                 exp_name[0], exp_data[0], rsp_rdata);
                        data_errs++;
                    end
                    if (cyc != exp_cyc[0]) begin
                        $display("** Error %s response cycle: expected %0d, actual %0d",
                                 exp_name[0], exp_cyc[0], cyc);
                        time_errs++;
                    end
                    void'(exp_data.pop_front());
                    void'(exp_cyc.pop_front());
                    void'(exp_name.pop_front());
                end
            end else if (exp_cyc.size() > 0 && exp_cyc[0] < cyc) begin
                $display("No response for %s by cycle %0d", exp_name[0], exp_cyc[0]);
                other_errs++;
                void'(exp_data.pop_front());
                void'(exp_cyc.pop_front());
                void'(exp_name.pop_front());
            end
            if (addr_err) begin
                if (err_cyc.size() == 0) begin
                    $display("addr_err pulsed at cycle %0d without a misaligned command", cyc);
                    flag_errs++;
                end else begin
                    if (cyc != err_cyc[0]) begin
                        $display("** Error %s addr_err cycle: expected %0d, actual %0d",
                                 err_name[0], err_cyc[0], cyc);
                        time_errs++;
                    end
                    void'(err_cyc.pop_front());
                    void'(err_name.pop_front());
                end
            end else if (err_cyc.size() > 0 && err_cyc[0] < cyc) begin
                $display("addr_err missing for %s", err_name[0]);
                flag_errs++;
                void'(err_cyc.pop_front());
                void'(err_name.pop_front());
            end
        end
    end

    // ##########################################################
    // Main sequence
    // ##########################################################

    initial begin
        void'($urandom(32'hb3554370));
        clk        = 1'b0;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = NOP;
        cmd_addr   = 32'd0;
        cmd_wdata  = 32'd0;
        cyc        = 0;
        data_errs  = 0;
        time_errs  = 0;
        flag_errs  = 0;
        other_errs = 0;
        timed_out  = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        check_idle(5);
        run_patterns();
        wait_drain("pattern");
        if (!timed_out) begin
            run_random();
            wait_drain("random");
        end
        $display("Errors: data %0d, timing %0d, addr_err %0d, other %0d",
                 data_errs, time_errs, flag_errs, other_errs);
        if (data_errs + time_errs + flag_errs + other_errs == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/10ps

module data_ram import mem_pkg::*; #(
    parameter int MEM_WORDS = DEFAULT_MEM_WORDS,
    parameter int DELAY     = DEFAULT_DELAY
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        data_req,
    input  logic        data_wr,
    input  mem_size_e   data_size,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata,
    output logic        data_addr_ok,
    output logic        data_data_ok
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]   mem [MEM_WORDS];
    logic [AW-1:0] word_idx;
    logic [3:0]    lane_mask;
    logic [31:0]   merged;
    logic [31:0]   rd_word;

    logic [31:0]      rdata_pipe [DELAY];
    logic [DELAY-1:0] ok_pipe;

    assign word_idx     = data_addr[AW+1:2];
    assign data_addr_ok = data_req;  // Every request accepted at once.

    // ##########################################################
    // Lane mask and write merge
    // ##########################################################

    always_comb begin
        case (data_size)
            SZ_BYTE:   lane_mask = 4'b0001 << data_addr[1:0];
            SZ_HALF:   lane_mask = 4'b0011 << data_addr[1:0];
            SZ_TRIPLE: lane_mask = 4'b0111 << data_addr[1:0];
            default:   lane_mask = 4'b1111;
        endcase
    end

    always_comb begin
        merged = mem[word_idx];
        for (int b = 0; b < 4; b++) begin
            if (lane_mask[b]) begin
                merged[8*b +: 8] = data_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_req && data_wr) begin
            mem[word_idx] <= merged;  // Commits at end of request cycle.
        end
    end

    // ##########################################################
    // Response delay line
    // ##########################################################

    // Writes return zero data.
    assign rd_word = (data_req && !data_wr) ? mem[word_idx] : 32'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            ok_pipe <= '0;
        end else begin
            ok_pipe[0] <= data_req;
            for (int i = 1; i < DELAY; i++) begin
                ok_pipe[i] <= ok_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata_pipe[0] <= rd_word;
        for (int i = 1; i < DELAY; i++) begin
            rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    assign data_rdata   = rdata_pipe[DELAY-1];
    assign data_data_ok = ok_pipe[DELAY-1];

endmodule

// ==== verilog/load_extend.sv ====
`timescale 1ns/10ps

module load_extend import mem_pkg::*; (
    input  logic             data_data_ok,
    input  logic [31:0]      data_rdata,
    input  logic [TAG_W-1:0] head_tag,
    output logic             pop,
    output logic             rsp_valid,
    output logic [31:0]      rsp_rdata
);

    lsu_op_e     op;
    logic [1:0]  byte_lo;
    logic        is_load;
    logic [31:0] shifted;

    // ##########################################################
    // Tag fields
    // ##########################################################

    assign op      = lsu_op_e'(head_tag[TAG_OP_LSB +: 4]);
    assign byte_lo = head_tag[TAG_LO_LSB +: 2];
    assign is_load = head_tag[TAG_LD_BIT];

    assign pop       = data_data_ok;  // One tag per response.
    assign rsp_valid = data_data_ok;

    // Addressed byte or halfword down to bit 0.
    assign shifted = data_rdata >> {byte_lo, 3'b000};

    // ##########################################################
    // Sign and zero extension
    // ##########################################################

    always_comb begin
        rsp_rdata = 32'd0;
        if (is_load) begin
            case (op)
                LB:  rsp_rdata = {{24{shifted[7]}}, shifted[7:0]};
                LBU: rsp_rdata = {24'd0, shifted[7:0]};
                LH:  rsp_rdata = {{16{shifted[15]}}, shifted[15:0]};
                LHU: rsp_rdata = {16'd0, shifted[15:0]};
                LW:  rsp_rdata = data_rdata;  // Always aligned.
                default: begin
                    rsp_rdata = 32'd0;
                end
            endcase
        end
    end

endmodule

// ==== verilog/lsu_request.sv ====
`timescale 1ns/10ps

module lsu_request import mem_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_valid,
    input  lsu_op_e          cmd_op,
    input  logic [31:0]      cmd_addr,
    input  logic [31:0]      cmd_wdata,
    output logic             data_req,
    output logic             data_wr,
    output mem_size_e        data_size,
    output logic [31:0]      data_addr,
    output logic [31:0]      data_wdata,
    input  logic             data_addr_ok,
    output logic             push,
    output logic [TAG_W-1:0] push_tag,
    output logic             addr_err
);

    logic is_mem;
    logic is_load;
    logic misaligned;

    // ##########################################################
    // Opcode decode
    // ##########################################################

    always_comb begin
        is_mem    = 1'b1;
        is_load   = 1'b0;
        data_wr   = 1'b0;
        data_size = SZ_WORD;
        case (cmd_op)
            LB, LBU: begin
                is_load   = 1'b1;
                data_size = SZ_BYTE;
            end
            LH, LHU: begin
                is_load   = 1'b1;
                data_size = SZ_HALF;
            end
            LW: begin
                is_load = 1'b1;
            end
            SB: begin
                data_wr   = 1'b1;
                data_size = SZ_BYTE;
            end
            SH: begin
                data_wr   = 1'b1;
                data_size = SZ_HALF;
            end
            SW: begin
                data_wr = 1'b1;
            end
            default: begin
                is_mem = 1'b0;  // NOP and unused codes.
            end
        endcase
    end

    always_comb begin
        case (data_size)
            SZ_HALF: misaligned = cmd_addr[0];
            SZ_WORD: misaligned = (cmd_addr[1:0] != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    // ##########################################################
    // RAM request and lane placement
    // ##########################################################

    assign data_req  = cmd_valid && is_mem && !misaligned;
    assign data_addr = cmd_addr;

    // Replicated so the RAM lane mask picks the right copy.
    always_comb begin
        case (cmd_op)
            SB:      data_wdata = {4{cmd_wdata[7:0]}};
            SH:      data_wdata = {2{cmd_wdata[15:0]}};
            SW:      data_wdata = cmd_wdata;
            default: data_wdata = 32'd0;
        endcase
    end

    assign push = data_req && data_addr_ok;

    always_comb begin
        push_tag                     = '0;
        push_tag[TAG_OP_LSB +: 4]    = cmd_op;
        push_tag[TAG_LO_LSB +: 2]    = cmd_addr[1:0];
        push_tag[TAG_LD_BIT]         = is_load;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_err <= 1'b0;
        end else begin
            addr_err <= cmd_valid && is_mem && misaligned;  // One cycle late.
        end
    end

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    // ##########################################################
    // Command opcodes and RAM access sizes
    // ##########################################################

    typedef enum logic [3:0] {
        LB  = 4'h0,  // Load byte, sign-extended.
        LBU = 4'h1,  // Load byte, zero-extended.
        LH  = 4'h2,
        LHU = 4'h3,
        LW  = 4'h4,
        SB  = 4'h5,
        SH  = 4'h6,
        SW  = 4'h7,
        NOP = 4'hf
    } lsu_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE   = 2'd0,
        SZ_HALF   = 2'd1,
        SZ_TRIPLE = 2'd2,  // Only the RAM decodes it.
        SZ_WORD   = 2'd3
    } mem_size_e;

    // ##########################################################
    // In-flight tag layout
    // ##########################################################

    // Tag is {load flag, address low bits, opcode}.
    localparam int TAG_W      = 7;
    localparam int TAG_OP_LSB = 0;  // Opcode, 4 bits.
    localparam int TAG_LO_LSB = 4;  // Byte offset, 2 bits.
    localparam int TAG_LD_BIT = 6;  // Set for loads.

    // ##########################################################
    // Memory defaults
    // ##########################################################

    localparam int DEFAULT_MEM_WORDS = 1024;  // Must be a power of two.
    localparam int DEFAULT_DELAY     = 2;     // At least 1.

endpackage

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top import mem_pkg::*; #(
    parameter int MEM_WORDS = DEFAULT_MEM_WORDS,
    parameter int DELAY     = DEFAULT_DELAY
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  lsu_op_e     cmd_op,
    input  logic [31:0] cmd_addr,
    input  logic [31:0] cmd_wdata,
    output logic        rsp_valid,
    output logic [31:0] rsp_rdata,
    output logic        addr_err
);

    logic             data_req;
    logic             data_wr;
    mem_size_e        data_size;
    logic [31:0]      data_addr;
    logic [31:0]      data_wdata;
    logic [31:0]      data_rdata;
    logic             data_addr_ok;
    logic             data_data_ok;
    logic             push;
    logic [TAG_W-1:0] push_tag;
    logic             pop;
    logic [TAG_W-1:0] head_tag;

    lsu_request lsu_request_i (
        .clk, .rst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_wdata,
        .data_req, .data_wr, .data_size, .data_addr, .data_wdata,
        .data_addr_ok, .push, .push_tag, .addr_err
    );

    // One slot more than the responses in flight.
    op_fifo #(.DEPTH(DELAY + 1), .WIDTH(TAG_W)) op_fifo_i (
        .clk, .rst, .push, .push_tag, .pop, .head_tag,
        .empty(), .full()
    );

    data_ram #(.MEM_WORDS(MEM_WORDS), .DELAY(DELAY)) data_ram_i (
        .clk, .rst, .data_req, .data_wr, .data_size, .data_addr, .data_wdata,
        .data_rdata, .data_addr_ok, .data_data_ok
    );

    load_extend load_extend_i (
        .data_data_ok, .data_rdata, .head_tag, .pop, .rsp_valid, .rsp_rdata
    );

endmodule

// ==== verilog/op_fifo.sv ====
`timescale 1ns/10ps

module op_fifo #(
    parameter int DEPTH = 3,
    parameter int WIDTH = 7
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_tag,
    input  logic             pop,
    output logic [WIDTH-1:0] head_tag,
    output logic             empty,
    output logic             full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head_tag = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_tag;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
